//--- bench/regfile_clock.sv
/*
  Clock and reset source for the register file testbench.
  20 ns period. rst is high for the first 8 rising edges
  and drops 2 ns after the 8th one.
*/
`timescale 1ns/1ns

module regfile_clock (
    output logic clk,
    output logic rst
);

    // ~~~~~~~~~~~~~~~~~~~~
    // Free-running clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period
    end

    // Reset, released off the edge like the other inputs
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

//--- bench/register_file_tb.sv
/*
  Testbench for the banked register file.
  Directed table first, then LFSR-driven random cycles checked
  against a 64-word reference model. Two write and two read ports assumed.
  Inputs change 2 ns after the rising edge and reads are sampled 5 ns later.
*/
`timescale 1ns/1ns
`include "regfile_defs.svh"

module register_file_tb;

    import regfile_pkg::*;

    localparam int          NUM_ROWS      = 14;
    localparam int          RANDOM_CYCLES = 200;
    localparam int          RESET_TIMEOUT = 50;          // Cycles
    localparam logic [31:0] LFSR_SEED     = 32'h786e;
    localparam logic [31:0] LFSR_TAPS     = 32'hA300_0000; // x^32+x^30+x^26+x^25+1

    logic                        clk;
    logic                        rst;
    phys_addr_t                  write_addr [`NUM_WRITE_PORTS];
    reg_data_t                   write_data [`NUM_WRITE_PORTS];
    logic [`NUM_WRITE_PORTS-1:0] commit;
    phys_addr_t                  read_addr [`NUM_READ_PORTS];
    reg_data_t                   read_data [`NUM_READ_PORTS];

    // ~~~~~~~~~~~~~~~~~~~~
    // Directed table with one row per cycle
    logic [1:0] tbl_commit [NUM_ROWS];            // {port 1, port 0}
    phys_addr_t tbl_waddr  [NUM_ROWS][2];
    reg_data_t  tbl_wdata  [NUM_ROWS][2];
    phys_addr_t tbl_raddr  [NUM_ROWS][2];
    reg_data_t  tbl_expect [NUM_ROWS][2];         // Same-cycle read values

    reg_data_t   ref_mem [`NUM_PHYS_REGS];        // Last committed value
    bit          written [`NUM_PHYS_REGS];        // Known to the model yet
    logic [31:0] lfsr;
    int          errors;
    int          checks;

    regfile_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    register_file u_register_file (
        .clk        (clk),
        .rst        (rst),
        .write_addr (write_addr),
        .write_data (write_data),
        .commit     (commit),
        .read_addr  (read_addr),
        .read_data  (read_data)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Helpers
    task automatic add_row(input int i, input logic [1:0] c,
                           input phys_addr_t a0, input reg_data_t d0,
                           input phys_addr_t a1, input reg_data_t d1,
                           input phys_addr_t r0, input phys_addr_t r1,
                           input reg_data_t e0, input reg_data_t e1);
        tbl_commit[i]    = c;
        tbl_waddr[i][0]  = a0;
        tbl_wdata[i][0]  = d0;
        tbl_waddr[i][1]  = a1;
        tbl_wdata[i][1]  = d1;
        tbl_raddr[i][0]  = r0;
        tbl_raddr[i][1]  = r1;
        tbl_expect[i][0] = e0;
        tbl_expect[i][1] = e1;
    endtask

    // Galois LFSR stepped once per bit returned
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return val;
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] expected,
                           input string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
        end
    endtask

    // Read model for the current cycle
    // known stays low for regs never written
    task automatic model_read(input phys_addr_t addr, output reg_data_t val,
                              output bit known);
        val   = ref_mem[addr];
        known = written[addr];
        for (int w = 0; w < `NUM_WRITE_PORTS; w++) begin
            if (commit[w] && write_addr[w] == addr) begin
                val   = write_data[w];              // Bypass where later port overrides
                known = 1'b1;
            end
        end
        if (addr == '0) begin
            val   = '0;                             // r0 always zero
            known = 1'b1;
        end
    endtask

    // Effect of the coming edge with the highest port applied last
    task automatic model_commit();
        for (int w = 0; w < `NUM_WRITE_PORTS; w++) begin
            if (commit[w]) begin
                ref_mem[write_addr[w]] = write_data[w];
                written[write_addr[w]] = 1'b1;
            end
        end
    endtask

    task automatic wait_reset_done(output bit ok);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (rst !== 1'b0 && cycles < RESET_TIMEOUT);
        ok = (rst === 1'b0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Table contents
    initial begin
        add_row(0,  2'b01, 5,  32'hA5A5_0001, 0, 32'h0,          5,  0,  32'hA5A5_0001, 32'h0);
        add_row(1,  2'b00, 0,  32'h0,         0, 32'h0,          5,  5,  32'hA5A5_0001,
                32'hA5A5_0001);
        add_row(2,  2'b11, 12, 32'h1212_0000, 9, 32'h0000_9999,  9,  12, 32'h0000_9999,
                32'h1212_0000);
        add_row(3,  2'b00, 0,  32'h0,         0, 32'h0,          12, 9,  32'h1212_0000,
                32'h0000_9999);
        add_row(4,  2'b01, 5,  32'h5555_0000, 0, 32'h0,          5,  9,  32'h5555_0000,
                32'h0000_9999);
        // Collision on r5 where port 1 wins even on the bypass
        add_row(5,  2'b11, 5,  32'hDEAD_0000, 5, 32'hBEEF_0001,  5,  5,  32'hBEEF_0001,
                32'hBEEF_0001);
        add_row(6,  2'b00, 0,  32'h0,         0, 32'h0,          5,  5,  32'hBEEF_0001,
                32'hBEEF_0001);
        add_row(7,  2'b11, 9,  32'h0000_00AA, 9, 32'h0000_00BB,  12, 9,  32'h1212_0000,
                32'h0000_00BB);
        // Writes to r0 never show up
        add_row(8,  2'b11, 0,  32'hFFFF_FFFF, 0, 32'h1234_5678,  0,  0,  32'h0,         32'h0);
        add_row(9,  2'b00, 0,  32'h0,         0, 32'h0,          0,  9,  32'h0,
                32'h0000_00BB);
        add_row(10, 2'b10, 0,  32'h0,         0, 32'hCAFE_F00D,  0,  5,  32'h0,
                32'hBEEF_0001);
        add_row(11, 2'b00, 0,  32'h0,         0, 32'h0,          0,  0,  32'h0,         32'h0);
        add_row(12, 2'b01, 9,  32'h9090_9090, 0, 32'h0,          9,  12, 32'h9090_9090,
                32'h1212_0000);
        add_row(13, 2'b00, 0,  32'h0,         0, 32'h0,          5,  9,  32'hBEEF_0001,
                32'h9090_9090);
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    initial begin
        bit          ok;
        bit          known;
        reg_data_t   exp_val;
        logic [31:0] strobes;
        logic [31:0] narrow;
        logic [31:0] pick;
        logic [31:0] port;

        lfsr   = LFSR_SEED;
        errors = 0;
        checks = 0;
        commit = '0;
        for (int w = 0; w < `NUM_WRITE_PORTS; w++) begin
            write_addr[w] = '0;
            write_data[w] = '0;
        end
        for (int r = 0; r < `NUM_READ_PORTS; r++) begin
            read_addr[r] = '0;
        end
        for (int i = 0; i < `NUM_PHYS_REGS; i++) begin
            ref_mem[i] = '0;
            written[i] = 1'b0;
        end

        wait_reset_done(ok);
        if (!ok) begin
            $display("Reset was still asserted after %0d cycles", RESET_TIMEOUT);
            $display("TEST FAILED");
            $finish;
        end else begin
            #2;
            // Directed rows
            for (int i = 0; i < NUM_ROWS; i++) begin
                commit = tbl_commit[i];
                for (int w = 0; w < 2; w++) begin
                    write_addr[w] = tbl_waddr[i][w];
                    write_data[w] = tbl_wdata[i][w];
                    read_addr[w]  = tbl_raddr[i][w];   // Two read ports as well
                end
                #5;                                    // Settle
                for (int r = 0; r < 2; r++) begin
                    compare(read_data[r], tbl_expect[i][r],
                            $sformatf("row %0d port %0d r%0d", i, r, read_addr[r]));
                end
                model_commit();
                @(posedge clk);
                #2;
            end

            // Random cycles with addresses often squeezed to r0..r7 for collisions
            for (int n = 0; n < RANDOM_CYCLES; n++) begin
                strobes = take_bits(2);
                commit  = strobes[`NUM_WRITE_PORTS-1:0];
                for (int w = 0; w < `NUM_WRITE_PORTS; w++) begin
                    narrow        = take_bits(1);
                    write_addr[w] = phys_addr_t'(take_bits(6));
                    if (narrow[0]) begin
                        write_addr[w] = write_addr[w] & 6'h07;
                    end
                    write_data[w] = take_bits(32);
                end
                for (int r = 0; r < `NUM_READ_PORTS; r++) begin
                    pick = take_bits(1);
                    if (pick[0]) begin
                        port         = take_bits(1);
                        read_addr[r] = write_addr[port[0]];  // Aim at a commit
                    end else begin
                        read_addr[r] = phys_addr_t'(take_bits(6));
                    end
                end
                #5;
                for (int r = 0; r < `NUM_READ_PORTS; r++) begin
                    model_read(read_addr[r], exp_val, known);
                    if (known) begin
                        compare(read_data[r], exp_val,
                                $sformatf("random cycle %0d port %0d r%0d", n, r,
                                          read_addr[r]));
                    end
                end
                model_commit();
                @(posedge clk);
                #2;
            end
            commit = '0;

            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

//--- filelist.f
+incdir+source
source/regfile_pkg.sv
source/write_port_filter.sv
source/register_bank.sv
source/live_value_table.sv
source/read_select.sv
source/register_file.sv
bench/regfile_clock.sv
bench/register_file_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the register file testbench with Verilator.
# Exits nonzero on a build error, a run error or a missing pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module register_file_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vregister_file_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

//--- source/live_value_table.sv
/*
  Live value table for the banked register file.
  Per physical register, the bank that last wrote it.
  Expects commit_ok to be collision free (one writer per entry per cycle).
  Reset points every entry at bank 0.
*/
`timescale 1ns/1ns
`include "regfile_defs.svh"

module live_value_table (
    input  logic                        clk,
    input  logic                        rst,
    input  regfile_pkg::phys_addr_t     write_addr [`NUM_WRITE_PORTS],
    input  logic [`NUM_WRITE_PORTS-1:0] commit_ok,
    input  regfile_pkg::phys_addr_t     read_addr [`NUM_READ_PORTS],
    output regfile_pkg::bank_id_t       read_bank [`NUM_READ_PORTS]
);

    import regfile_pkg::*;

    bank_id_t lvt [`NUM_PHYS_REGS];    // Flops, not RAM, since reset clears them

    // ~~~~~~~~~~~~~~~~~~~~
    // Update
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_PHYS_REGS; i++) begin
                lvt[i] <= '0;                          // All point at bank 0
            end
        end else begin
            // Filter guarantees distinct addresses here
            for (int w = 0; w < `NUM_WRITE_PORTS; w++) begin
                if (commit_ok[w]) begin
                    lvt[write_addr[w]] <= bank_id_t'(w);  // Port index = bank index
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Lookup
    // Combinational, one per read port
    generate
        for (genvar r = 0; r < `NUM_READ_PORTS; r++) begin : g_lookup
            assign read_bank[r] = lvt[read_addr[r]];
        end
    endgenerate

    // Entries only change on a filtered commit,
    // so a losing port never redirects a register to its bank

endmodule

//--- source/read_select.sv
/*
  Output mux for each issue read port.
  Priority, lowest to highest: LVT bank, same-cycle bypass, r0 zero.
  Bypass uses commit_ok, so it agrees with the collision winner.
  Purely combinational.
*/
`timescale 1ns/1ns
`include "regfile_defs.svh"

module read_select (
    input  regfile_pkg::phys_addr_t     read_addr [`NUM_READ_PORTS],
    input  regfile_pkg::bank_id_t       read_bank [`NUM_READ_PORTS],
    input  regfile_pkg::reg_data_t      bank_data [`NUM_WRITE_PORTS][`NUM_READ_PORTS],
    input  regfile_pkg::phys_addr_t     write_addr [`NUM_WRITE_PORTS],
    input  regfile_pkg::reg_data_t      write_data [`NUM_WRITE_PORTS],
    input  logic [`NUM_WRITE_PORTS-1:0] commit_ok,
    output regfile_pkg::reg_data_t      read_data [`NUM_READ_PORTS]
);

    import regfile_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // Per read port
    always_comb begin
        reg_data_t sel;
        for (int r = 0; r < `NUM_READ_PORTS; r++) begin
            // Bank named by the LVT
            sel = bank_data[read_bank[r]][r];

            // Same-cycle bypass from an accepted commit
            // Only one port can match after filtering, so order is irrelevant
            for (int w = 0; w < `NUM_WRITE_PORTS; w++) begin
                if (commit_ok[w] && (write_addr[w] == read_addr[r])) begin
                    sel = write_data[w];
                end
            end

            // r0 is hardwired zero
            if (read_addr[r] == '0) begin
                sel = '0;                              // Even if committed
            end

            read_data[r] = sel;
        end
    end

    // A commit to r0 still writes the bank and the LVT,
    // but nothing ever reads that entry back

endmodule

//--- source/regfile_defs.svh
/*
  Sizing for the physical register file.
  One bank per write port, so bank ids need $clog2(NUM_WRITE_PORTS) bits.
  NUM_WRITE_PORTS must be at least 2 for a nonzero bank id width.
*/
`ifndef REGFILE_DEFS_SVH
`define REGFILE_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Port counts
`define NUM_WRITE_PORTS 2   // Commit ports, one bank each
`define NUM_READ_PORTS  2   // Issue read ports

// ~~~~~~~~~~~~~~~~~~~~
// Storage
`define NUM_PHYS_REGS   64  // Physical registers, r0 reads as zero
`define DATA_WIDTH      32  // Register value width

`endif

//--- source/regfile_pkg.sv
/*
  Vector types shared by the register file blocks.
  Widths follow the macros in the defs header.
*/
`include "regfile_defs.svh"

package regfile_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Register addressing and payload

    // Physical register index
    typedef logic [$clog2(`NUM_PHYS_REGS)-1:0] phys_addr_t;

    // One register value
    typedef logic [`DATA_WIDTH-1:0] reg_data_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Bank selection

    // Which bank holds the latest copy, 1 bit for two banks
    typedef logic [$clog2(`NUM_WRITE_PORTS)-1:0] bank_id_t;

endpackage

//--- source/register_bank.sv
/*
  One storage bank, one write port, all read ports.
  No reset on the storage. Zeroed by an initial block for simulation only.
  Reads are asynchronous, so the RAM must map to distributed/LUT memory.
*/
`timescale 1ns/1ns
`include "regfile_defs.svh"

module register_bank (
    input  logic                    clk,
    input  regfile_pkg::phys_addr_t write_addr,
    input  regfile_pkg::reg_data_t  write_data,
    input  logic                    write_en,
    input  regfile_pkg::phys_addr_t read_addr [`NUM_READ_PORTS],
    output regfile_pkg::reg_data_t  read_data [`NUM_READ_PORTS]
);

    import regfile_pkg::*;

    (* ram_style = "distributed" *) reg_data_t bank_mem [`NUM_PHYS_REGS];

    // ~~~~~~~~~~~~~~~~~~~~
    // Storage
    initial begin
        for (int i = 0; i < `NUM_PHYS_REGS; i++) begin
            bank_mem[i] = '0;                          // Sim start value
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            bank_mem[write_addr] <= write_data;        // Lands at the edge
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Read ports
    // Combinational, one mux per issue port
    generate
        for (genvar r = 0; r < `NUM_READ_PORTS; r++) begin : g_read
            assign read_data[r] = bank_mem[read_addr[r]];
        end
    endgenerate

endmodule

//--- source/register_file.sv
/*
  Banked physical register file for an out-of-order issue stage.
  NUM_WRITE_PORTS commit ports, NUM_READ_PORTS combinational reads.
  Same-address commits in one cycle: highest port wins.
  Commits are single-cycle strobes with no back-pressure.
  Bank storage is not reset; only the LVT is.
*/
`timescale 1ns/1ns
`include "regfile_defs.svh"

module register_file (
    input  logic                        clk,
    input  logic                        rst,
    input  regfile_pkg::phys_addr_t     write_addr [`NUM_WRITE_PORTS],
    input  regfile_pkg::reg_data_t      write_data [`NUM_WRITE_PORTS],
    input  logic [`NUM_WRITE_PORTS-1:0] commit,
    input  regfile_pkg::phys_addr_t     read_addr [`NUM_READ_PORTS],
    output regfile_pkg::reg_data_t      read_data [`NUM_READ_PORTS]
);

    import regfile_pkg::*;

    logic [`NUM_WRITE_PORTS-1:0] commit_ok;                             // Filtered strobes
    reg_data_t                   bank_data [`NUM_WRITE_PORTS][`NUM_READ_PORTS];
    bank_id_t                    read_bank [`NUM_READ_PORTS];            // LVT result

    // ~~~~~~~~~~~~~~~~~~~~
    // Write path
    write_port_filter u_filter (
        .write_addr (write_addr),
        .commit     (commit),
        .commit_ok  (commit_ok)
    );

    // One bank per commit port
    generate
        for (genvar i = 0; i < `NUM_WRITE_PORTS; i++) begin : g_bank
            register_bank u_bank (
                .clk        (clk),
                .write_addr (write_addr[i]),
                .write_data (write_data[i]),
                .write_en   (commit_ok[i]),
                .read_addr  (read_addr),
                .read_data  (bank_data[i])
            );
        end
    endgenerate

    live_value_table u_lvt (
        .clk        (clk),
        .rst        (rst),
        .write_addr (write_addr),
        .commit_ok  (commit_ok),
        .read_addr  (read_addr),
        .read_bank  (read_bank)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Read path
    read_select u_select (
        .read_addr  (read_addr),
        .read_bank  (read_bank),
        .bank_data  (bank_data),
        .write_addr (write_addr),
        .write_data (write_data),
        .commit_ok  (commit_ok),
        .read_data  (read_data)
    );

endmodule

//--- source/write_port_filter.sv
/*
  Same-cycle collision filter for the commit ports.
  Higher-numbered port wins; the losers see commit_ok low.
  Purely combinational, no clock.
*/
`timescale 1ns/1ns
`include "regfile_defs.svh"

module write_port_filter (
    input  regfile_pkg::phys_addr_t   write_addr [`NUM_WRITE_PORTS],
    input  logic [`NUM_WRITE_PORTS-1:0] commit,
    output logic [`NUM_WRITE_PORTS-1:0] commit_ok
);

    import regfile_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // Priority by port number
    always_comb begin
        for (int p = 0; p < `NUM_WRITE_PORTS; p++) begin
            commit_ok[p] = commit[p];                  // Start from raw strobe
            // Any later port hitting the same register takes over
            for (int q = p + 1; q < `NUM_WRITE_PORTS; q++) begin
                if (commit[q] && (write_addr[q] == write_addr[p])) begin
                    commit_ok[p] = 1'b0;               // Lost the collision
                end
            end
        end
    end

    // At most one commit_ok per address from here on,
    // which the LVT and the bypass both rely on

endmodule
